//--- hdl/soc_pkg.sv
// Shared widths, address map and register indices for the Wishbone fabric.
// Region codes compare address bits 31..17 only; the rest select inside a slave.
// Peripheral registers are word-aligned, indexed by address bits 3..2.
`default_nettype none

package soc_pkg;

	// --------------------
	// Bus widths
	localparam int unsigned WB_ADR_W = 32;
	localparam int unsigned WB_DAT_W = 32;
	// One select bit per byte lane
	localparam int unsigned WB_SEL_W = WB_DAT_W / 8;

	// --------------------
	// Address map, upper 15 bits
	localparam int unsigned REGION_W = 15;
	localparam logic [REGION_W-1:0] REGION_BRAM  = 15'h0000;
	localparam logic [REGION_W-1:0] REGION_TIMER = 15'h7001;
	localparam logic [REGION_W-1:0] REGION_GPIO  = 15'h7002;

	// Register index inside a peripheral
	localparam int unsigned REG_IDX_W = 2;

	// Timer registers
	localparam logic [REG_IDX_W-1:0] TMR_CTRL    = 2'd0;
	localparam logic [REG_IDX_W-1:0] TMR_COMPARE = 2'd1;
	localparam logic [REG_IDX_W-1:0] TMR_COUNT   = 2'd2;
	localparam logic [REG_IDX_W-1:0] TMR_STATUS  = 2'd3;

	// GPIO registers
	localparam logic [REG_IDX_W-1:0] GPIO_IN   = 2'd0;
	localparam logic [REG_IDX_W-1:0] GPIO_OUT  = 2'd1;
	localparam logic [REG_IDX_W-1:0] GPIO_MASK = 2'd2;
	localparam logic [REG_IDX_W-1:0] GPIO_PEND = 2'd3;
	// 4 buttons + 4 switches in, 8 LEDs out
	localparam int unsigned GPIO_W = 8;

	// --------------------
	// Interrupt vector, active low at the top level
	localparam int unsigned INTR_W     = 32;
	localparam int unsigned INTR_TIMER = 0;
	localparam int unsigned INTR_GPIO  = 1;

endpackage

`default_nettype wire

//--- hdl/wb_if.sv
// Wishbone classic bundle for single transfers, no err/rty/cti/bte lines.
// Widths come in as parameters from the instantiating level.
`timescale 1ns/1ps
`default_nettype none

interface wb_if #(
	parameter int unsigned ADR_W = 32,
	parameter int unsigned DAT_W = 32,
	parameter int unsigned SEL_W = 4
) ();

	// Master side
	logic             cyc;
	logic             stb;
	logic             we;
	logic [ADR_W-1:0] adr;
	logic [SEL_W-1:0] sel;
	logic [DAT_W-1:0] dat_w;

	// Slave side
	logic [DAT_W-1:0] dat_r;
	logic             ack;

	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, sel, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

//--- hdl/wb_decoder.sv
// One master to three slaves, picked by address bits 31..17.
// Unmapped regions get a local ack one cycle after the strobe, with zero data.
// Read data and ack are muxed by the same region compare, so the master
// must hold its address until ack.
`timescale 1ns/1ps
`default_nettype none

module wb_decoder import soc_pkg::*; (
	input  logic   clk_i,
	input  logic   reset_i,
	wb_if.slave    host,
	wb_if.master   bram,
	wb_if.master   timer,
	wb_if.master   gpio
);

	logic [REGION_W-1:0] region;
	logic                hit_bram;
	logic                hit_timer;
	logic                hit_gpio;
	logic                hit_none;
	logic                ack_none_q;

	// --------------------
	// Region compare
	assign region    = host.adr[WB_ADR_W-1 -: REGION_W];
	assign hit_bram  = (region == REGION_BRAM);
	assign hit_timer = (region == REGION_TIMER);
	assign hit_gpio  = (region == REGION_GPIO);
	assign hit_none  = !(hit_bram || hit_timer || hit_gpio);

	// Shared request lines go to every slave
	assign bram.adr   = host.adr;
	assign bram.we    = host.we;
	assign bram.sel   = host.sel;
	assign bram.dat_w = host.dat_w;

	assign timer.adr   = host.adr;
	assign timer.we    = host.we;
	assign timer.sel   = host.sel;
	assign timer.dat_w = host.dat_w;

	assign gpio.adr   = host.adr;
	assign gpio.we    = host.we;
	assign gpio.sel   = host.sel;
	assign gpio.dat_w = host.dat_w;

	// Strobe and cycle only toward the selected slave
	assign bram.cyc  = host.cyc & hit_bram;
	assign bram.stb  = host.stb & hit_bram;
	assign timer.cyc = host.cyc & hit_timer;
	assign timer.stb = host.stb & hit_timer;
	assign gpio.cyc  = host.cyc & hit_gpio;
	assign gpio.stb  = host.stb & hit_gpio;

	// --------------------
	// Unmapped responder
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_none_q <= 1'b0;
		end else begin
			// Single-cycle ack, same latency as the slaves
			ack_none_q <= host.cyc & host.stb & hit_none & ~ack_none_q;
		end
	end

	// Return path
	always_comb begin
		if (hit_bram) begin
			host.ack   = bram.ack;
			host.dat_r = bram.dat_r;
		end else if (hit_timer) begin
			host.ack   = timer.ack;
			host.dat_r = timer.dat_r;
		end else if (hit_gpio) begin
			host.ack   = gpio.ack;
			host.dat_r = gpio.dat_r;
		end else begin
			host.ack   = ack_none_q;
			host.dat_r = '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/wb_bram.sv
// Single-port word RAM, 2**BRAM_ADR_W words, byte-lane writes via sel.
// Address bits above the RAM depth are ignored, so the region aliases.
// Contents are undefined after power-up; reset only clears the ack.
`timescale 1ns/1ps
`default_nettype none

module wb_bram import soc_pkg::*; #(
	parameter int unsigned BRAM_ADR_W = 10
) (
	input  logic   clk_i,
	input  logic   reset_i,
	wb_if.slave    bus
);

	logic [WB_DAT_W-1:0]   mem [2**BRAM_ADR_W];
	logic [BRAM_ADR_W-1:0] word_idx;
	logic                  req;
	logic                  ack_q;
	logic [WB_DAT_W-1:0]   rd_q;

	// Word address, byte offset dropped
	assign word_idx = bus.adr[BRAM_ADR_W+1:2];
	// New strobe only, not the ack cycle
	assign req      = bus.cyc & bus.stb & ~ack_q;

	// Handshake
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	// Storage and read register
	always_ff @(posedge clk_i) begin
		if (req) begin
			// Old word on a write cycle
			rd_q <= mem[word_idx];
			if (bus.we) begin
				for (int lane = 0; lane < WB_SEL_W; lane++) begin
					if (bus.sel[lane]) begin
						mem[word_idx][8*lane +: 8] <= bus.dat_w[8*lane +: 8];
					end
				end
			end
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

//--- hdl/wb_gpio.sv
// GPIO with LED output register and rising-edge interrupt.
// Inputs pass a two-flop synchronizer; pending bits are write-one-to-clear.
// Registers are written as whole words, byte selects ignored.
`timescale 1ns/1ps
`default_nettype none

module wb_gpio import soc_pkg::*; (
	input  logic              clk_i,
	input  logic              reset_i,
	wb_if.slave               bus,
	input  logic [GPIO_W-1:0] pins_i,
	output logic [GPIO_W-1:0] leds_o,
	output logic              irq_o
);

	logic [GPIO_W-1:0]    pins_meta;
	logic [GPIO_W-1:0]    pins_sync;
	logic [GPIO_W-1:0]    pins_prev;
	logic [GPIO_W-1:0]    rise;
	logic [GPIO_W-1:0]    out_q;
	logic [GPIO_W-1:0]    mask_q;
	logic [GPIO_W-1:0]    pend_q;
	logic [GPIO_W-1:0]    pend_clr;
	logic [REG_IDX_W-1:0] reg_idx;
	logic                 req;
	logic                 wr;
	logic                 ack_q;
	logic                 irq_q;
	logic [WB_DAT_W-1:0]  rd_q;

	assign reg_idx  = bus.adr[REG_IDX_W+1:2];
	assign req      = bus.cyc & bus.stb & ~ack_q;
	assign wr       = req & bus.we;
	assign rise     = pins_sync & ~pins_prev;
	assign pend_clr = (wr && reg_idx == GPIO_PEND) ? bus.dat_w[GPIO_W-1:0] : '0;

	// --------------------
	// Sync, edge detect, interrupt
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pins_meta <= '0;
			pins_sync <= '0;
			pins_prev <= '0;
			pend_q    <= '0;
			irq_q     <= 1'b0;
		end else begin
			pins_meta <= pins_i;
			pins_sync <= pins_meta;
			pins_prev <= pins_sync;
			// New edges win over a clear in the same cycle
			pend_q    <= (pend_q & ~pend_clr) | (rise & mask_q);
			irq_q     <= |pend_q;
		end
	end

	// Bus side registers
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q  <= 1'b0;
			out_q  <= '0;
			mask_q <= '0;
		end else begin
			ack_q <= req;
			if (wr && reg_idx == GPIO_OUT) begin
				out_q <= bus.dat_w[GPIO_W-1:0];
			end
			if (wr && reg_idx == GPIO_MASK) begin
				mask_q <= bus.dat_w[GPIO_W-1:0];
			end
		end
	end

	// Read data, held for the ack cycle
	always_ff @(posedge clk_i) begin
		if (req) begin
			case (reg_idx)
				GPIO_IN:   rd_q <= WB_DAT_W'(pins_sync);
				GPIO_OUT:  rd_q <= WB_DAT_W'(out_q);
				GPIO_MASK: rd_q <= WB_DAT_W'(mask_q);
				default:   rd_q <= WB_DAT_W'(pend_q);
			endcase
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;
	assign leds_o    = out_q;
	assign irq_o     = irq_q;

endmodule

`default_nettype wire

//--- hdl/wb_timer.sv
// Compare timer: 32-bit counter, one compare, optional auto-reload.
// CTRL bit 0 enable, bit 1 auto-reload, bit 2 interrupt enable.
// Any write to STATUS clears the match bit; whole-word writes only.
`timescale 1ns/1ps
`default_nettype none

module wb_timer import soc_pkg::*; (
	input  logic   clk_i,
	input  logic   reset_i,
	wb_if.slave    bus,
	output logic   irq_o
);

	localparam int unsigned CTRL_EN     = 0;
	localparam int unsigned CTRL_RELOAD = 1;
	localparam int unsigned CTRL_IRQ    = 2;

	logic [2:0]           ctrl_q;
	logic [WB_DAT_W-1:0]  compare_q;
	logic [WB_DAT_W-1:0]  count_q;
	logic                 match_q;
	logic                 hit;
	logic [REG_IDX_W-1:0] reg_idx;
	logic                 req;
	logic                 wr;
	logic                 ack_q;
	logic [WB_DAT_W-1:0]  rd_q;

	assign reg_idx = bus.adr[REG_IDX_W+1:2];
	assign req     = bus.cyc & bus.stb & ~ack_q;
	assign wr      = req & bus.we;
	// Compare only counts while running
	assign hit     = ctrl_q[CTRL_EN] && (count_q == compare_q);

	// --------------------
	// Counter and control
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ctrl_q    <= '0;
			compare_q <= '0;
			count_q   <= '0;
			match_q   <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= req;

			// Free-running part
			if (hit) begin
				if (ctrl_q[CTRL_RELOAD]) begin
					count_q <= '0;
				end else begin
					// One-shot, stop on compare
					ctrl_q[CTRL_EN] <= 1'b0;
				end
			end else if (ctrl_q[CTRL_EN]) begin
				count_q <= count_q + 1'b1;
			end

			// Bus writes override the counter update
			if (wr) begin
				case (reg_idx)
					TMR_CTRL:    ctrl_q    <= bus.dat_w[2:0];
					TMR_COMPARE: compare_q <= bus.dat_w;
					TMR_COUNT:   count_q   <= bus.dat_w;
					default:     match_q   <= 1'b0;
				endcase
			end

			// Sticky match, set wins over clear
			if (hit) begin
				match_q <= 1'b1;
			end
		end
	end

	// Read data for the ack cycle
	always_ff @(posedge clk_i) begin
		if (req) begin
			case (reg_idx)
				TMR_CTRL:    rd_q <= WB_DAT_W'(ctrl_q);
				TMR_COMPARE: rd_q <= compare_q;
				TMR_COUNT:   rd_q <= count_q;
				default:     rd_q <= WB_DAT_W'(match_q);
			endcase
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;
	assign irq_o     = match_q & ctrl_q[CTRL_IRQ];

endmodule

`default_nettype wire

//--- hdl/soc_top.sv
// Wishbone fabric top: external classic master, BRAM, timer and GPIO.
// One transfer at a time; every ack comes one cycle after the strobe.
// intr_n_o is active low, timer at bit 0 and GPIO at bit 1, rest held high.
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
	parameter int unsigned BRAM_ADR_W = 10
) (
	input  logic                clk_i,
	input  logic                reset_i,
	// Wishbone master port
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_SEL_W-1:0] wb_sel_i,
	input  logic [WB_DAT_W-1:0] wb_dat_i,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	output logic                wb_ack_o,
	// Board I/O
	input  logic [3:0]          btn_i,
	input  logic [3:0]          sw_i,
	output logic [GPIO_W-1:0]   led_o,
	output logic [INTR_W-1:0]   intr_n_o
);

	logic timer_irq;
	logic gpio_irq;

	// --------------------
	// Buses
	wb_if #(.ADR_W(WB_ADR_W), .DAT_W(WB_DAT_W), .SEL_W(WB_SEL_W)) host_bus ();
	wb_if #(.ADR_W(WB_ADR_W), .DAT_W(WB_DAT_W), .SEL_W(WB_SEL_W)) bram_bus ();
	wb_if #(.ADR_W(WB_ADR_W), .DAT_W(WB_DAT_W), .SEL_W(WB_SEL_W)) timer_bus ();
	wb_if #(.ADR_W(WB_ADR_W), .DAT_W(WB_DAT_W), .SEL_W(WB_SEL_W)) gpio_bus ();

	// External master onto the host bus
	assign host_bus.cyc   = wb_cyc_i;
	assign host_bus.stb   = wb_stb_i;
	assign host_bus.we    = wb_we_i;
	assign host_bus.adr   = wb_adr_i;
	assign host_bus.sel   = wb_sel_i;
	assign host_bus.dat_w = wb_dat_i;
	assign wb_dat_o       = host_bus.dat_r;
	assign wb_ack_o       = host_bus.ack;

	wb_decoder decoder0 (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.host    (host_bus),
		.bram    (bram_bus),
		.timer   (timer_bus),
		.gpio    (gpio_bus)
	);

	// --------------------
	// Slaves
	wb_bram #(
		.BRAM_ADR_W (BRAM_ADR_W)
	) bram0 (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.bus     (bram_bus)
	);

	wb_timer timer0 (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.bus     (timer_bus),
		.irq_o   (timer_irq)
	);

	// Switches in the upper nibble, buttons below
	wb_gpio gpio0 (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.bus     (gpio_bus),
		.pins_i  ({sw_i, btn_i}),
		.leds_o  (led_o),
		.irq_o   (gpio_irq)
	);

	// Interrupt vector, unused lines inactive
	always_comb begin
		intr_n_o             = '1;
		intr_n_o[INTR_TIMER] = ~timer_irq;
		intr_n_o[INTR_GPIO]  = ~gpio_irq;
	end

endmodule

`default_nettype wire

//--- test/tb_soc.sv
// Directed testbench for the Wishbone fabric, one master transfer at a time.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// BRAM powers up undefined, so each test word is written in full first.
`timescale 1ns/1ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

	// Falling edges from driving the strobe until ack is seen
	localparam int ACK_WAIT = 2;
	localparam int TIMEOUT  = 200;
	localparam int NWORDS   = 8;
	localparam logic [REGION_W-1:0] REGION_HOLE = 15'h1234;

	logic        clk_i;
	logic        reset_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [31:0] wb_adr_i;
	logic [3:0]  wb_sel_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic [3:0]  btn_i;
	logic [3:0]  sw_i;
	logic [7:0]  led_o;
	logic [31:0] intr_n_o;

	int          errors;
	int          checks;
	int          ack_lat;
	// Reference model of the BRAM words under test
	int unsigned bram_idx [NWORDS];
	logic [31:0] bram_model [NWORDS];

	soc_top #(.BRAM_ADR_W(10)) uut (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_sel_i (wb_sel_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.btn_i    (btn_i),
		.sw_i     (sw_i),
		.led_o    (led_o),
		.intr_n_o (intr_n_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// --------------------
	// Helpers
	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERROR t=%0t %s", $time, what);
		end
	endtask

	function automatic logic [31:0] reg_addr(input logic [REGION_W-1:0] region,
			input logic [1:0] idx);
		return {region, 13'd0, idx, 2'b00};
	endfunction

	function automatic logic [31:0] bram_addr(input int unsigned idx);
		return {20'd0, idx[9:0], 2'b00};
	endfunction

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// One classic transfer; latency left in ack_lat
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int n;
		@(posedge clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_sel_i <= sel;
		wb_dat_i <= wdat;
		@(negedge clk_i);
		n = 1;
		while (!wb_ack_o && n < TIMEOUT) begin
			@(negedge clk_i);
			n++;
		end
		ack_lat = n;
		rdat    = wb_dat_o;
		check_true(wb_ack_o, $sformatf("no ack for address %h", adr));
		// Master drops the strobe after ack
		@(posedge clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		@(negedge clk_i);
		check_true(!wb_ack_o, $sformatf("ack longer than one cycle at %h", adr));
	endtask

	task automatic wait_intr(input int bit_pos, input logic level, input string what);
		int n;
		n = 0;
		while (intr_n_o[bit_pos] !== level && n < TIMEOUT) begin
			@(negedge clk_i);
			n++;
		end
		check_true(intr_n_o[bit_pos] === level, what);
	endtask

	// Every vector line other than active_bit must be high
	task automatic check_idle_lines(input int active_bit);
		check_equal("intr_n_o", intr_n_o | (32'd1 << active_bit), 32'hFFFF_FFFF);
	endtask

	task automatic check_bram();
		logic [31:0] rd;
		for (int i = 0; i < NWORDS; i++) begin
			bus_cycle(1'b0, bram_addr(bram_idx[i]), 4'hF, 32'd0, rd);
			check_equal($sformatf("bram[%0d]", bram_idx[i]), rd, bram_model[i]);
		end
	endtask

	// --------------------
	// Tests
	task automatic test_reset_state();
		check_equal("wb_ack_o", 32'(wb_ack_o), 32'd0);
		check_equal("led_o", 32'(led_o), 32'd0);
		check_equal("intr_n_o", intr_n_o, 32'hFFFF_FFFF);
	endtask

	task automatic test_bram();
		logic [31:0] rd;
		logic [31:0] data;
		logic [3:0]  sel;
		int          k;
		// Low bits keep the indices distinct
		for (int i = 0; i < NWORDS; i++) begin
			bram_idx[i]   = (($urandom % 128) * NWORDS) + i;
			bram_model[i] = $urandom;
			bus_cycle(1'b1, bram_addr(bram_idx[i]), 4'hF, bram_model[i], rd);
		end
		for (int j = 0; j < 24; j++) begin
			k    = $urandom % NWORDS;
			data = $urandom;
			sel  = 4'($urandom);
			bus_cycle(1'b1, bram_addr(bram_idx[k]), sel, data, rd);
			bram_model[k] = merge_lanes(bram_model[k], data, sel);
		end
		check_bram();
	endtask

	task automatic test_ack_timing();
		logic [31:0] probe [4];
		logic [31:0] rd;
		probe[0] = bram_addr(bram_idx[0]);
		probe[1] = reg_addr(REGION_TIMER, TMR_COUNT);
		probe[2] = reg_addr(REGION_GPIO, GPIO_IN);
		probe[3] = reg_addr(REGION_HOLE, 2'd0);
		for (int i = 0; i < 4; i++) begin
			bus_cycle(1'b0, probe[i], 4'hF, 32'd0, rd);
			check_equal($sformatf("ack latency at %h", probe[i]), 32'(ack_lat), ACK_WAIT);
		end
	endtask

	task automatic test_gpio_io();
		logic [31:0] rd;
		logic [31:0] data;
		logic [3:0]  btn_val;
		logic [3:0]  sw_val;
		data = $urandom;
		bus_cycle(1'b1, reg_addr(REGION_GPIO, GPIO_OUT), 4'hF, data, rd);
		check_equal("led_o", 32'(led_o), 32'(data[7:0]));
		btn_val = 4'hA;
		sw_val  = 4'h5;
		@(posedge clk_i);
		btn_i <= btn_val;
		sw_i  <= sw_val;
		// Synchronizer delay
		repeat (3) @(posedge clk_i);
		bus_cycle(1'b0, reg_addr(REGION_GPIO, GPIO_IN), 4'hF, 32'd0, rd);
		check_equal("GPIO_IN", rd, {24'd0, sw_val, btn_val});
		@(posedge clk_i);
		btn_i <= 4'd0;
		sw_i  <= 4'd0;
		repeat (3) @(posedge clk_i);
	endtask

	task automatic test_gpio_irq();
		logic [31:0] rd;
		// Only button 2 unmasked
		bus_cycle(1'b1, reg_addr(REGION_GPIO, GPIO_MASK), 4'hF, 32'h4, rd);
		@(posedge clk_i);
		btn_i <= 4'b0100;
		wait_intr(INTR_GPIO, 1'b0, "GPIO interrupt did not assert");
		check_idle_lines(INTR_GPIO);
		bus_cycle(1'b0, reg_addr(REGION_GPIO, GPIO_PEND), 4'hF, 32'd0, rd);
		check_equal("GPIO_PEND", rd, 32'h4);
		// Edge on masked-off button 1
		@(posedge clk_i);
		btn_i <= 4'b0110;
		repeat (4) @(posedge clk_i);
		bus_cycle(1'b0, reg_addr(REGION_GPIO, GPIO_PEND), 4'hF, 32'd0, rd);
		check_equal("GPIO_PEND", rd, 32'h4);
		bus_cycle(1'b1, reg_addr(REGION_GPIO, GPIO_PEND), 4'hF, 32'h4, rd);
		wait_intr(INTR_GPIO, 1'b1, "GPIO interrupt did not release");
		check_equal("intr_n_o", intr_n_o, 32'hFFFF_FFFF);
		@(posedge clk_i);
		btn_i <= 4'd0;
	endtask

	task automatic test_timer();
		logic [31:0] rd;
		logic [31:0] cmp;
		cmp = 32'd16 + ($urandom % 32);
		bus_cycle(1'b1, reg_addr(REGION_TIMER, TMR_COMPARE), 4'hF, cmp, rd);
		bus_cycle(1'b1, reg_addr(REGION_TIMER, TMR_COUNT), 4'hF, 32'd0, rd);
		// Enable plus interrupt enable, one-shot
		bus_cycle(1'b1, reg_addr(REGION_TIMER, TMR_CTRL), 4'hF, 32'h5, rd);
		wait_intr(INTR_TIMER, 1'b0, "timer interrupt did not assert");
		check_idle_lines(INTR_TIMER);
		bus_cycle(1'b0, reg_addr(REGION_TIMER, TMR_STATUS), 4'hF, 32'd0, rd);
		check_equal("TMR_STATUS", rd, 32'h1);
		bus_cycle(1'b0, reg_addr(REGION_TIMER, TMR_CTRL), 4'hF, 32'd0, rd);
		check_equal("TMR_CTRL", rd, 32'h4);
		bus_cycle(1'b1, reg_addr(REGION_TIMER, TMR_STATUS), 4'hF, 32'h1, rd);
		wait_intr(INTR_TIMER, 1'b1, "timer interrupt did not release");
		check_equal("intr_n_o", intr_n_o, 32'hFFFF_FFFF);
	endtask

	task automatic test_unmapped();
		logic [31:0] rd;
		logic [31:0] hole;
		// Same offset as a live BRAM word
		hole = {REGION_HOLE, 5'd0, bram_idx[0][9:0], 2'b00};
		bus_cycle(1'b0, hole, 4'hF, 32'd0, rd);
		check_equal("unmapped read", rd, 32'd0);
		bus_cycle(1'b1, hole, 4'hF, $urandom, rd);
		check_bram();
	endtask

	// --------------------
	// Sequence
	initial begin
		void'($urandom(32'h23));
		errors = 0;
		checks = 0;
		reset_i  <= 1'b1;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		wb_adr_i <= 32'd0;
		wb_sel_i <= 4'd0;
		wb_dat_i <= 32'd0;
		btn_i    <= 4'd0;
		sw_i     <= 4'd0;
		repeat (10) @(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		test_reset_state();
		test_bram();
		test_ack_timing();
		test_gpio_io();
		test_gpio_irq();
		test_timer();
		test_unmapped();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- soc.f
hdl/soc_pkg.sv
hdl/wb_if.sv
hdl/wb_decoder.sv
hdl/wb_bram.sv
hdl/wb_gpio.sv
hdl/wb_timer.sv
hdl/soc_top.sv
test/tb_soc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_soc
FILELIST  ?= soc.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
